// ==== flist.f ====
+incdir+include
source/cache_pkg.sv
source/cache_line_store.sv
source/cache_ctrl.sv
source/main_memory.sv
source/cache_subsystem.sv
verif/cache_tb.sv

// ==== verif/cache_tb.sv ====
/*
 * cache subsystem testbench
 * directed and random reads checked against a memory, tag and latency model
 */
`default_nettype none

`include "cache_config.svh"

module cache_tb
  import cache_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // response latency in edges from acceptance to the first edge that sees rsp_valid
  localparam int hit_latency     = 1;
  localparam int miss_latency    = `MEM_LATENCY + 3;
  localparam int preload_words   = 20 * `CACHE_LINES;
  localparam int random_reqs     = 200;
  localparam int num_reqs        = 28 + random_reqs;
  localparam int watchdog_cycles = num_reqs * (`MEM_LATENCY + 10) + preload_words + 50;

  typedef struct packed {
    logic        hit;
    logic [7:0]  data;
    logic [31:0] accept_cycle;
  } expect_t;

  logic        clk;
  logic        rst;
  logic        req_valid;
  cache_addr_t req_addr;
  logic        req_ready;
  logic        rsp_valid;
  logic [7:0]  rsp_data;
  logic        rsp_ready;
  logic        load_stb;
  mem_load_t   load;

  // reference copy of main memory and of the tag/valid state
  logic [`CACHE_WORD_W-1:0] mem_model [0:(1<<`MEM_ADDR_W)-1];
  logic                     model_valid [0:`CACHE_LINES-1];
  logic [`CACHE_TAG_W-1:0]  model_tag [0:`CACHE_LINES-1];

  expect_t    exp_q[$];
  int         errors;
  int         cycle_cnt;
  int         accept_count;
  int         rsp_count;
  int         miss_count;
  logic       head_seen;
  logic [7:0] held_byte;
  // 0 ready always high, 1 random ready, 2 ready driven by the test
  int         rdy_mode;

  cache_subsystem i_dut (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_ready (req_ready),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .rsp_ready (rsp_ready),
    .load_stb  (load_stb),
    .load      (load)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: tests did not complete within %0d clock cycles", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // big-endian byte of the word held in the memory model
  function automatic logic [7:0] expected_byte(input cache_addr_t a);
    logic [`CACHE_WORD_W-1:0] word;
    int                       shift;
    word  = mem_model[{a.tag, a.index}];
    shift = 24 - 8 * int'(a.offset);
    return word[shift +: 8];
  endfunction

  // response ready pattern, changed on the falling edge
  always @(negedge clk) begin
    if (rdy_mode == 0) begin
      rsp_ready = 1'b1;
    end else if (rdy_mode == 1) begin
      rsp_ready = ($urandom_range(3) != 0);
    end
  end

  // monitor sees pre-edge values, responses are retired before new requests enter
  always @(posedge clk) begin
    expect_t ent;
    int      lat;
    if (!rst) begin
      cycle_cnt++;
      // an offered response stays offered until it is taken
      if (head_seen) begin
        check_value("rsp_valid_hold", 32'(rsp_valid), 32'd1);
      end
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response seen at %0t while no request was outstanding", $time);
        end else begin
          if (!head_seen) begin
            lat = cycle_cnt - int'(exp_q[0].accept_cycle);
            check_value("rsp_latency", 32'(lat),
                        exp_q[0].hit ? 32'(hit_latency) : 32'(miss_latency));
            // a late first response marks a miss in the DUT
            if (lat > hit_latency) begin
              miss_count++;
            end
            head_seen = 1'b1;
            held_byte = rsp_data;
          end else begin
            check_value("rsp_data_hold", 32'(rsp_data), 32'(held_byte));
          end
          if (!rsp_ready) begin
            check_value("req_ready", 32'(req_ready), 32'd0);
          end else begin
            check_value("rsp_data", 32'(rsp_data), 32'(exp_q[0].data));
            ent       = exp_q.pop_front();
            head_seen = 1'b0;
            rsp_count++;
          end
        end
      end
      if (req_valid && req_ready) begin
        ent.hit          = model_valid[req_addr.index] &&
                           (model_tag[req_addr.index] == req_addr.tag);
        ent.data         = expected_byte(req_addr);
        ent.accept_cycle = 32'(cycle_cnt);
        model_valid[req_addr.index] = 1'b1;
        model_tag[req_addr.index]   = req_addr.tag;
        exp_q.push_back(ent);
        accept_count++;
      end
    end
  end

  task automatic preload_mem;
    mem_load_t ld;
    int        w;
    for (w = 0; w < preload_words; w++) begin
      ld.addr = `MEM_ADDR_W'(w);
      ld.data = $urandom() ^ (32'(w) * 32'h9e37_79b9);
      mem_model[ld.addr] = ld.data;
      @(negedge clk);
      load_stb = 1'b1;
      load     = ld;
    end
    @(negedge clk);
    load_stb = 1'b0;
  endtask

  // returns at the edge that accepts the request
  task automatic send_req(input cache_addr_t addr);
    @(negedge clk);
    req_valid = 1'b1;
    req_addr  = addr;
    @(posedge clk);
    while (!req_ready) @(posedge clk);
  endtask

  task automatic drain_rsp;
    @(negedge clk);
    req_valid = 1'b0;
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
  endtask

  task automatic test_cold_start;
    int base;
    int i;
    base = miss_count;
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    check_value("req_ready", 32'(req_ready), 32'd1);
    for (i = 0; i < 8; i++) begin
      send_req('{tag: 8'(i + 1), index: 6'(i * 7), offset: 2'(i)});
    end
    drain_rsp();
    check_value("cold_misses", 32'(miss_count - base), 32'd8);
  endtask

  task automatic test_repeat;
    int base;
    int i;
    base = miss_count;
    for (i = 0; i < 8; i++) begin
      send_req('{tag: 8'(i + 1), index: 6'(i * 7), offset: 2'(i)});
    end
    drain_rsp();
    check_value("repeat_misses", 32'(miss_count - base), 32'd0);
  endtask

  task automatic test_byte_select;
    int base;
    int i;
    base = miss_count;
    for (i = 0; i < 4; i++) begin
      send_req('{tag: 8'd9, index: 6'd33, offset: 2'(i)});
    end
    drain_rsp();
    check_value("byte_select_misses", 32'(miss_count - base), 32'd1);
  endtask

  // same index, two tags evicting each other
  task automatic test_conflict;
    int base;
    int i;
    base = miss_count;
    for (i = 0; i < 6; i++) begin
      send_req('{tag: 8'(16 + (i % 2)), index: 6'd20, offset: 2'(i)});
    end
    drain_rsp();
    check_value("conflict_misses", 32'(miss_count - base), 32'd6);
  endtask

  task automatic test_backpressure;
    int base;
    base     = accept_count;
    rdy_mode = 2;
    send_req('{tag: 8'd12, index: 6'd40, offset: 2'd1});
    @(negedge clk);
    rsp_ready = 1'b0;
    req_addr  = '{tag: 8'd12, index: 6'd41, offset: 2'd2};
    repeat (`MEM_LATENCY + 8) @(negedge clk);
    // second request must still be waiting with the first response parked
    check_value("accept_count", 32'(accept_count - base), 32'd1);
    check_value("rsp_valid", 32'(rsp_valid), 32'd1);
    rsp_ready = 1'b1;
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    drain_rsp();
    rdy_mode = 0;
    check_value("backpressure_accepts", 32'(accept_count - base), 32'd2);
  endtask

  task automatic test_random;
    cache_addr_t addr;
    int          i;
    rdy_mode = 1;
    for (i = 0; i < random_reqs; i++) begin
      addr.tag    = 8'($urandom_range(3));
      addr.index  = 6'($urandom());
      addr.offset = 2'($urandom());
      send_req(addr);
    end
    drain_rsp();
    rdy_mode = 0;
  endtask

  initial begin
    int i;
    void'($urandom(12));
    rst          = 1'b1;
    req_valid    = 1'b0;
    req_addr     = '0;
    rsp_ready    = 1'b1;
    load_stb     = 1'b0;
    load         = '0;
    errors       = 0;
    cycle_cnt    = 0;
    accept_count = 0;
    rsp_count    = 0;
    miss_count   = 0;
    head_seen    = 1'b0;
    held_byte    = '0;
    rdy_mode     = 0;
    for (i = 0; i < `CACHE_LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    preload_mem();
    test_cold_start();
    test_repeat();
    test_byte_select();
    test_conflict();
    test_backpressure();
    test_random();

    check_value("rsp_count", 32'(rsp_count), 32'(accept_count));
    $display("requests %0d responses %0d misses %0d errors %0d",
             accept_count, rsp_count, miss_count, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/cache_subsystem.sv ====
/*
 * read-only cache subsystem
 * direct-mapped cache controller, line store and backing memory
 */
`default_nettype none

`include "cache_config.svh"

module cache_subsystem
  import cache_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         rst,
  input  wire logic         req_valid,
  input  wire cache_addr_t  req_addr,
  output logic              req_ready,
  output logic              rsp_valid,
  output logic [7:0]        rsp_data,
  input  wire logic         rsp_ready,
  input  wire logic         load_stb,
  input  wire mem_load_t    load
);

  // controller to line store
  logic                      rd_en;
  logic [`CACHE_INDEX_W-1:0] rd_index;
  cache_line_t               rd_line;
  logic                      fill_en;
  logic [`CACHE_INDEX_W-1:0] fill_index;
  logic [`CACHE_TAG_W-1:0]   fill_tag;

  // controller to main memory
  logic                      mem_stb;
  mem_req_t                  mem_req;
  logic                      mem_ack;
  logic [`CACHE_WORD_W-1:0]  mem_data;

  cache_ctrl i_ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .req_ready  (req_ready),
    .rsp_valid  (rsp_valid),
    .rsp_data   (rsp_data),
    .rsp_ready  (rsp_ready),
    .rd_en      (rd_en),
    .rd_index   (rd_index),
    .rd_line    (rd_line),
    .fill_en    (fill_en),
    .fill_index (fill_index),
    .fill_tag   (fill_tag),
    .mem_stb    (mem_stb),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack)
  );

  // fill data comes straight from the memory read port
  cache_line_store i_lines (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (rd_en),
    .rd_index   (rd_index),
    .rd_line    (rd_line),
    .fill_en    (fill_en),
    .fill_index (fill_index),
    .fill_tag   (fill_tag),
    .fill_data  (mem_data)
  );

  main_memory i_mem (
    .clk      (clk),
    .rst      (rst),
    .mem_stb  (mem_stb),
    .mem_req  (mem_req),
    .mem_ack  (mem_ack),
    .mem_data (mem_data),
    .load_stb (load_stb),
    .load     (load)
  );

endmodule

`default_nettype wire

// ==== source/main_memory.sv ====
/*
 * main memory model
 * word array with a preload port and a fixed latency strobe/ack read port
 */
`default_nettype none

`include "cache_config.svh"

module main_memory
  import cache_pkg::*;
(
  input  wire logic                     clk,
  input  wire logic                     rst,

  // read port toward the cache
  input  wire logic                     mem_stb,
  input  wire mem_req_t                 mem_req,
  output logic                          mem_ack,
  output logic [`CACHE_WORD_W-1:0]      mem_data,

  // preload port
  input  wire logic                     load_stb,
  input  wire mem_load_t                load
);

  localparam int count_w = $clog2(`MEM_LATENCY + 1);
  localparam int depth   = 1 << `MEM_ADDR_W;

  logic [`CACHE_WORD_W-1:0] words [0:depth-1];

  mem_state_e               state;
  logic [count_w-1:0]       count;
  logic [`MEM_ADDR_W-1:0]   addr_q;
  logic                     start;
  logic                     done;

  assign start = (state == mem_idle) && mem_stb;

  // last wait cycle, the word is registered for the respond state
  assign done = (state == mem_wait) && (count <= count_w'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_idle;
      count <= '0;
    end else begin
      case (state)
        mem_idle: begin
          if (mem_stb) begin
            state <= mem_wait;
            count <= count_w'(`MEM_LATENCY - 1);
          end
        end
        mem_wait: begin
          if (done) begin
            state <= mem_respond;
          end else begin
            count <= count - 1'b1;
          end
        end
        mem_respond: begin
          state <= mem_idle;
        end
        default: begin
          state <= mem_idle;
        end
      endcase
    end
  end

  // address is captured once so the requester may move on after the ack
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= mem_req.addr;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      mem_data <= words[addr_q];
    end
  end

  // preload, only used while no read is in flight
  always_ff @(posedge clk) begin
    if (load_stb) begin
      words[load.addr] <= load.data;
    end
  end

  assign mem_ack = (state == mem_respond);

endmodule

`default_nettype wire

// ==== source/cache_ctrl.sv ====
/*
 * cache controller
 * lookup stage, hit check, byte select and miss handling toward main memory
 */
`default_nettype none

`include "cache_config.svh"

module cache_ctrl
  import cache_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst,

  // requester side
  input  wire logic                      req_valid,
  input  wire cache_addr_t               req_addr,
  output logic                           req_ready,
  output logic                           rsp_valid,
  output logic [7:0]                     rsp_data,
  input  wire logic                      rsp_ready,

  // line store
  output logic                           rd_en,
  output logic [`CACHE_INDEX_W-1:0]      rd_index,
  input  wire cache_line_t               rd_line,
  output logic                           fill_en,
  output logic [`CACHE_INDEX_W-1:0]      fill_index,
  output logic [`CACHE_TAG_W-1:0]        fill_tag,

  // main memory
  output logic                           mem_stb,
  output mem_req_t                       mem_req,
  input  wire logic                      mem_ack
);

  // lookup stage
  logic        stage_valid;
  cache_addr_t held_addr;

  logic hit;
  logic ack_d;
  logic sel_held;

  // the stored line matches the request held in the stage
  assign hit = rd_line.valid && (rd_line.tag == held_addr.tag);

  // a new request enters when the current response leaves
  assign req_ready = rsp_ready && (hit || !stage_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else if (req_ready) begin
      stage_valid <= req_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_ready) begin
      held_addr <= req_addr;
    end
  end

  // one cycle after the acknowledge the filled line is read again
  always_ff @(posedge clk) begin
    if (rst) begin
      ack_d <= 1'b0;
    end else begin
      ack_d <= mem_ack;
    end
  end

  assign sel_held = mem_ack || ack_d;

  // read port, normally addressed by the incoming request
  assign rd_en    = req_ready || ack_d;
  assign rd_index = sel_held ? held_addr.index : req_addr.index;

  // fill straight from the memory acknowledge
  assign fill_en    = mem_ack;
  assign fill_index = held_addr.index;
  assign fill_tag   = held_addr.tag;

  assign rsp_valid = stage_valid && hit;

  // big-endian byte order within the word
  always_comb begin
    case (held_addr.offset)
      2'd0:    rsp_data = rd_line.data[31:24];
      2'd1:    rsp_data = rd_line.data[23:16];
      2'd2:    rsp_data = rd_line.data[15:8];
      default: rsp_data = rd_line.data[7:0];
    endcase
  end

  // miss request, masked while the refilled line is not yet back
  assign mem_stb      = stage_valid && !hit && !ack_d;
  assign mem_req.addr = {held_addr.tag, held_addr.index};

endmodule

`default_nettype wire

// ==== source/cache_line_store.sv ====
/*
 * cache line store
 * tag, valid and data arrays with a registered read port and a fill port
 */
`default_nettype none

`include "cache_config.svh"

module cache_line_store
  import cache_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      rd_en,
  input  wire logic [`CACHE_INDEX_W-1:0] rd_index,
  output cache_line_t                    rd_line,
  input  wire logic                      fill_en,
  input  wire logic [`CACHE_INDEX_W-1:0] fill_index,
  input  wire logic [`CACHE_TAG_W-1:0]   fill_tag,
  input  wire logic [`CACHE_WORD_W-1:0]  fill_data
);

  // line contents, no reset
  logic [`CACHE_TAG_W-1:0]  tag_mem  [0:`CACHE_LINES-1];
  logic [`CACHE_WORD_W-1:0] data_mem [0:`CACHE_LINES-1];

  // one valid bit per line, cleared by reset
  logic [`CACHE_LINES-1:0] valid_bits;

  // read port registers
  logic                     rd_valid;
  logic [`CACHE_TAG_W-1:0]  rd_tag;
  logic [`CACHE_WORD_W-1:0] rd_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_bits <= '0;
    end else if (fill_en) begin
      valid_bits[fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_mem[fill_index]  <= fill_tag;
      data_mem[fill_index] <= fill_data;
    end
  end

  // the read valid follows the valid bits through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else if (rd_en) begin
      rd_valid <= valid_bits[rd_index];
    end
  end

  // read holds its last value while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_tag  <= tag_mem[rd_index];
      rd_data <= data_mem[rd_index];
    end
  end

  assign rd_line = '{valid: rd_valid, tag: rd_tag, data: rd_data};

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
/*
 * cache types
 * address, line, memory request and load structs plus the memory FSM states
 */
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

  // requester byte address
  typedef struct packed {
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] offset;
  } cache_addr_t;

  // one cache line as read from the line store
  typedef struct packed {
    logic                     valid;
    logic [`CACHE_TAG_W-1:0]  tag;
    logic [`CACHE_WORD_W-1:0] data;
  } cache_line_t;

  // word read request toward main memory
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0] addr;
  } mem_req_t;

  // preload write into main memory
  typedef struct packed {
    logic [`MEM_ADDR_W-1:0]   addr;
    logic [`CACHE_WORD_W-1:0] data;
  } mem_load_t;

  typedef enum logic [1:0] {
    mem_idle,
    mem_wait,
    mem_respond
  } mem_state_e;

endpackage

`default_nettype wire

// ==== include/cache_config.svh ====
/*
 * cache configuration
 * address split, line count and backing memory latency
 */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address split into tag, index and offset
`define CACHE_TAG_W     8
`define CACHE_INDEX_W   6
`define CACHE_OFFSET_W  2
`define CACHE_ADDR_W    16

// one word per line
`define CACHE_WORD_W    32
`define CACHE_LINES     64

// word address into main memory is tag plus index
`define MEM_ADDR_W      (`CACHE_TAG_W + `CACHE_INDEX_W)

// cycles from strobe seen to acknowledge
`define MEM_LATENCY     4

`endif
